// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := stm_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --assert --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/stm_config.svh ====
/*
 * Size settings for the shared table memory.
 * All counts must be powers of two; derived widths are kept by hand
 * and have to be updated together with the counts they depend on.
 */
`ifndef STM_CONFIG_SVH
`define STM_CONFIG_SVH

// Storage organisation
`define STM_BANKS    4      // Banks in the table
`define STM_CHUNKS   2      // Chunks per bank, also words per line
`define STM_ROWS     16     // Rows in each RAM

// Access ports
`define STM_RPORTS   2      // Read ports, higher index wins a conflict

// Data
`define STM_DATA_W   16     // Bits per word

// Derived address widths
// Word address is {bank, row, chunk offset}
`define STM_CHUNK_AW 1      // log2(STM_CHUNKS)
`define STM_ROW_AW   4      // log2(STM_ROWS)
`define STM_BANK_AW  2      // log2(STM_BANKS)
`define STM_ADDR_W   7      // Full word address

`endif

// ==== common/stm_pkg.sv ====
/*
 * Shared types for the table memory.
 * A line is {bank, row}; incrementing it may carry into the bank field
 * and wraps from the last bank back to bank 0.
 */
`include "stm_config.svh"

package stm_pkg;

    typedef logic [`STM_DATA_W-1:0]         word_t;  // One data word
    typedef logic [`STM_ROW_AW-1:0]         row_t;   // Row inside a RAM
    typedef logic [`STM_BANK_AW-1:0]        bank_t;  // Bank index
    typedef logic [$clog2(`STM_RPORTS)-1:0] port_t;  // Read port index
    typedef logic [`STM_CHUNK_AW-1:0]       offs_t;  // Chunk offset of a word
    typedef logic [`STM_ADDR_W-1:0]         addr_t;  // Word address

    // Line of CHUNKS words, bank in the upper bits
    typedef struct packed {
        bank_t bank;
        row_t  row;
    } line_t;

    // What a bank chunk does in one cycle
    typedef enum logic [1:0] {
        REQ_IDLE,       // Nothing requested
        REQ_READ,       // Granted read
        REQ_WRITE,      // Write only
        REQ_READ_LOST   // Read requested but lost the RAM cycle
    } req_kind_e;

    // Line that feeds a chunk; chunks below the offset take the next line
    function automatic line_t chunk_line(input addr_t addr, input int unsigned chunk);
        line_t line;
        line = addr[`STM_ADDR_W-1:`STM_CHUNK_AW];
        if (chunk < addr[`STM_CHUNK_AW-1:0]) begin
            line = line + 1'b1;                 // Carry may cross into bank bits
        end
        return line;
    endfunction

endpackage

// ==== common/stm_rd_req_if.sv ====
/*
 * Read requests from the read decoder to the bank merge block.
 * Plain one-cycle strobes, no handshake; the merge must accept every cycle.
 */
`timescale 1ns/1ps
`include "stm_config.svh"

interface stm_rd_req_if;

    // Indexed [bank][chunk]
    logic          [`STM_BANKS-1:0][`STM_CHUNKS-1:0] rd_vld;   // Read granted
    stm_pkg::row_t [`STM_BANKS-1:0][`STM_CHUNKS-1:0] rd_row;   // Row to read
    stm_pkg::port_t [`STM_BANKS-1:0][`STM_CHUNKS-1:0] rd_port; // Winning port

    // Indexed [port][chunk]; enabled reads that lost to a higher port
    logic [`STM_RPORTS-1:0][`STM_CHUNKS-1:0] rd_lost;

    // Decoder side
    modport src (
        output rd_vld, rd_row, rd_port, rd_lost
    );

    // Bank merge side
    modport dst (
        input rd_vld, rd_row, rd_port, rd_lost
    );

endinterface

// ==== hw/stm_bank_merge/stm_bank_merge.sv ====
/*
 * Owns the bank RAMs and returns read data to the ports.
 * A write beats a read on the same bank chunk; the losing read returns
 * zero with its collision bit set. Output data is per chunk, unrotated.
 */
`timescale 1ns/1ps
`include "stm_config.svh"

module stm_bank_merge (
    input  logic                                             cclk,
    input  logic                                             rst_n_i,
    stm_rd_req_if.dst                                        req,
    input  logic [`STM_BANKS-1:0][`STM_CHUNKS-1:0]           wr_en_i,
    input  stm_pkg::row_t  [`STM_CHUNKS-1:0]                 wr_row_i,
    input  stm_pkg::word_t [`STM_CHUNKS-1:0]                 wr_data_i,
    input  stm_pkg::offs_t [`STM_RPORTS-1:0]                 tag_offs_i,
    input  logic [`STM_RPORTS-1:0]                           tag_vld_i,
    output stm_pkg::word_t [`STM_RPORTS-1:0][`STM_CHUNKS-1:0] rdata_o,
    output logic [`STM_RPORTS-1:0]                           rvalid_o,
    output stm_pkg::offs_t [`STM_RPORTS-1:0]                 roffs_o,
    output logic [`STM_RPORTS-1:0][`STM_CHUNKS-1:0]          rcoll_o
);

    stm_pkg::req_kind_e kind   [`STM_BANKS][`STM_CHUNKS];   // Stage 1 outcome
    stm_pkg::req_kind_e q_kind [`STM_BANKS][`STM_CHUNKS];   // Held across the RAM cycle
    stm_pkg::port_t     q_port [`STM_BANKS][`STM_CHUNKS];   // Owner of the RAM data

    logic [`STM_RPORTS-1:0][`STM_CHUNKS-1:0]           q_lost;     // Lost to a higher port
    stm_pkg::word_t [`STM_BANKS-1:0][`STM_CHUNKS-1:0]  ram_rdata;
    stm_pkg::word_t [`STM_RPORTS-1:0][`STM_CHUNKS-1:0] port_data;
    logic [`STM_RPORTS-1:0][`STM_CHUNKS-1:0]           port_coll;

    // Classify each bank chunk, write has priority
    always_comb begin
        for (int b = 0; b < `STM_BANKS; b++) begin
            for (int c = 0; c < `STM_CHUNKS; c++) begin
                if (wr_en_i[b][c] && req.rd_vld[b][c]) begin
                    kind[b][c] = stm_pkg::REQ_READ_LOST;
                end else if (wr_en_i[b][c]) begin
                    kind[b][c] = stm_pkg::REQ_WRITE;
                end else if (req.rd_vld[b][c]) begin
                    kind[b][c] = stm_pkg::REQ_READ;
                end else begin
                    kind[b][c] = stm_pkg::REQ_IDLE;
                end
            end
        end
    end

    // One RAM per bank chunk, write row overrides the read row
    for (genvar g_b = 0; g_b < `STM_BANKS; g_b++) begin : g_bank
        for (genvar g_c = 0; g_c < `STM_CHUNKS; g_c++) begin : g_chunk
            stm_ram u_ram (
                .cclk    (cclk),
                .en_i    (kind[g_b][g_c] != stm_pkg::REQ_IDLE),
                .we_i    (wr_en_i[g_b][g_c]),
                .addr_i  (wr_en_i[g_b][g_c] ? wr_row_i[g_c] : req.rd_row[g_b][g_c]),
                .wdata_i (wr_data_i[g_c]),
                .rdata_o (ram_rdata[g_b][g_c])
            );
        end
    end

    // E2 stage, lines up with the RAM output
    always_ff @(posedge cclk) begin
        if (!rst_n_i) begin
            q_lost <= '0;
            for (int b = 0; b < `STM_BANKS; b++) begin
                for (int c = 0; c < `STM_CHUNKS; c++) begin
                    q_kind[b][c] <= stm_pkg::REQ_IDLE;
                end
            end
        end else begin
            q_lost <= req.rd_lost;
            q_kind <= kind;
        end
    end

    always_ff @(posedge cclk) begin
        for (int b = 0; b < `STM_BANKS; b++) begin
            for (int c = 0; c < `STM_CHUNKS; c++) begin
                q_port[b][c] <= req.rd_port[b][c];     // Only used with q_kind
            end
        end
    end

    // Bank chain per port chunk; a port chunk hits at most one bank
    always_comb begin
        port_data = '0;
        port_coll = q_lost;                             // Lost to a higher port
        for (int p = 0; p < `STM_RPORTS; p++) begin
            for (int c = 0; c < `STM_CHUNKS; c++) begin
                for (int b = 0; b < `STM_BANKS; b++) begin
                    if (q_port[b][c] == stm_pkg::port_t'(p)) begin
                        if (q_kind[b][c] == stm_pkg::REQ_READ) begin
                            port_data[p][c] = ram_rdata[b][c];
                        end
                        if (q_kind[b][c] == stm_pkg::REQ_READ_LOST) begin
                            port_coll[p][c] = 1'b1;     // Lost to the write
                        end
                    end
                end
            end
        end
    end

    // E3 output stage
    always_ff @(posedge cclk) begin
        if (!rst_n_i) begin
            rvalid_o <= '0;
            rcoll_o  <= '0;
        end else begin
            rvalid_o <= tag_vld_i;
            rcoll_o  <= port_coll;
        end
    end

    always_ff @(posedge cclk) begin
        rdata_o <= port_data;                           // Zero where nothing was read
        roffs_o <= tag_offs_i;
    end

endmodule

// ==== hw/stm_bank_merge/stm_ram.sv ====
/*
 * Single-port synchronous RAM for one bank chunk.
 * Read data appears one edge after the request; a write leaves it alone.
 * Contents are not reset.
 */
`timescale 1ns/1ps
`include "stm_config.svh"

module stm_ram (
    input  logic           cclk,
    input  logic           en_i,       // Access this cycle
    input  logic           we_i,       // Write when set, else read
    input  stm_pkg::row_t  addr_i,
    input  stm_pkg::word_t wdata_i,
    output stm_pkg::word_t rdata_o
);

    stm_pkg::word_t mem [`STM_ROWS];   // Row storage

    always_ff @(posedge cclk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];   // Holds until the next read
            end
        end
    end

endmodule

// ==== hw/stm_rd_decode.sv ====
/*
 * Read request decode for all read ports.
 * Per bank and chunk the highest enabled port wins; lower ports are
 * flagged lost. Requests are registered once, tags twice, so the tags
 * meet the RAM data in the merge block.
 */
`timescale 1ns/1ps
`include "stm_config.svh"

module stm_rd_decode (
    input  logic                                     cclk,
    input  logic                                     rst_n_i,
    input  logic [`STM_RPORTS-1:0][`STM_CHUNKS-1:0]  ren_i,      // Per port chunk enables
    input  stm_pkg::addr_t [`STM_RPORTS-1:0]         raddr_i,    // Per port start address
    stm_rd_req_if.src                                req,
    output stm_pkg::offs_t [`STM_RPORTS-1:0]         tag_offs_o, // Offset, two cycles late
    output logic [`STM_RPORTS-1:0]                   tag_vld_o   // Any enable, two cycles late
);

    stm_pkg::line_t    line  [`STM_RPORTS][`STM_CHUNKS];  // Line of each port chunk
    stm_pkg::req_kind_e pkind [`STM_RPORTS][`STM_CHUNKS]; // Port level outcome

    logic           [`STM_BANKS-1:0][`STM_CHUNKS-1:0] gnt_vld;
    stm_pkg::row_t  [`STM_BANKS-1:0][`STM_CHUNKS-1:0] gnt_row;
    stm_pkg::port_t [`STM_BANKS-1:0][`STM_CHUNKS-1:0] gnt_port;
    logic           [`STM_RPORTS-1:0][`STM_CHUNKS-1:0] lost;

    logic           [`STM_RPORTS-1:0] q_vld_s1;           // First tag stage
    stm_pkg::offs_t [`STM_RPORTS-1:0] q_offs_s1;

    // Chunk lines per port
    always_comb begin
        for (int p = 0; p < `STM_RPORTS; p++) begin
            for (int c = 0; c < `STM_CHUNKS; c++) begin
                line[p][c] = stm_pkg::chunk_line(raddr_i[p], c);
            end
        end
    end

    // Port arbitration, a higher port hitting the same bank takes the chunk
    always_comb begin
        for (int p = 0; p < `STM_RPORTS; p++) begin
            for (int c = 0; c < `STM_CHUNKS; c++) begin
                pkind[p][c] = ren_i[p][c] ? stm_pkg::REQ_READ : stm_pkg::REQ_IDLE;
                for (int q = p + 1; q < `STM_RPORTS; q++) begin
                    if (ren_i[p][c] && ren_i[q][c] &&
                        (line[q][c].bank == line[p][c].bank)) begin
                        pkind[p][c] = stm_pkg::REQ_READ_LOST;
                    end
                end
                lost[p][c] = (pkind[p][c] == stm_pkg::REQ_READ_LOST);
            end
        end
    end

    // Route each winner to its bank, at most one per bank chunk
    always_comb begin
        gnt_vld  = '0;
        gnt_row  = '0;
        gnt_port = '0;
        for (int b = 0; b < `STM_BANKS; b++) begin
            for (int c = 0; c < `STM_CHUNKS; c++) begin
                for (int p = 0; p < `STM_RPORTS; p++) begin
                    if ((pkind[p][c] == stm_pkg::REQ_READ) &&
                        (line[p][c].bank == stm_pkg::bank_t'(b))) begin
                        gnt_vld[b][c]  = 1'b1;
                        gnt_row[b][c]  = line[p][c].row;
                        gnt_port[b][c] = stm_pkg::port_t'(p);
                    end
                end
            end
        end
    end

    // Strobes and tag valids, cleared by reset
    always_ff @(posedge cclk) begin
        if (!rst_n_i) begin
            req.rd_vld  <= '0;
            req.rd_lost <= '0;
            q_vld_s1    <= '0;
            tag_vld_o   <= '0;
        end else begin
            req.rd_vld  <= gnt_vld;                   // E1
            req.rd_lost <= lost;
            for (int p = 0; p < `STM_RPORTS; p++) begin
                q_vld_s1[p] <= |ren_i[p];
            end
            tag_vld_o   <= q_vld_s1;                  // E2, merge takes it at E3
        end
    end

    // Payload, only meaningful with the matching valid
    always_ff @(posedge cclk) begin
        req.rd_row  <= gnt_row;
        req.rd_port <= gnt_port;
        for (int p = 0; p < `STM_RPORTS; p++) begin
            q_offs_s1[p] <= raddr_i[p][`STM_CHUNK_AW-1:0];
        end
        tag_offs_o  <= q_offs_s1;
    end

endmodule

// ==== hw/stm_top.sv ====
/*
 * Shared table memory, two read ports and one write port.
 * Read results come out three edges after the request is sampled, one
 * cycle wide, per chunk and unrotated with the start offset. No back-pressure.
 */
`timescale 1ns/1ps
`include "stm_config.svh"

module stm_top (
    input  logic                                              cclk,
    input  logic                                              rst_n_i,
    input  logic [`STM_RPORTS-1:0][`STM_CHUNKS-1:0]           i_ren_i,
    input  stm_pkg::addr_t [`STM_RPORTS-1:0]                  i_raddr_i,
    input  logic [`STM_CHUNKS-1:0]                            i_wen_i,
    input  stm_pkg::addr_t                                    i_waddr_i,
    input  stm_pkg::word_t [`STM_CHUNKS-1:0]                  i_wdata_i,
    output logic [`STM_RPORTS-1:0]                            o_rvalid_o,
    output stm_pkg::offs_t [`STM_RPORTS-1:0]                  o_roffs_o,
    output stm_pkg::word_t [`STM_RPORTS-1:0][`STM_CHUNKS-1:0] o_rdata_o,
    output logic [`STM_RPORTS-1:0][`STM_CHUNKS-1:0]           o_rcoll_o
);

    // Write path, decode to merge
    logic [`STM_BANKS-1:0][`STM_CHUNKS-1:0] wr_en;
    stm_pkg::row_t  [`STM_CHUNKS-1:0]       wr_row;
    stm_pkg::word_t [`STM_CHUNKS-1:0]       wr_data;

    // Read tags, delayed to the RAM output
    stm_pkg::offs_t [`STM_RPORTS-1:0]       tag_offs;
    logic [`STM_RPORTS-1:0]                 tag_vld;

    stm_rd_req_if rd_req_if ();

    stm_rd_decode u_rd_decode (
        .cclk       (cclk),
        .rst_n_i    (rst_n_i),
        .ren_i      (i_ren_i),
        .raddr_i    (i_raddr_i),
        .req        (rd_req_if.src),
        .tag_offs_o (tag_offs),
        .tag_vld_o  (tag_vld)
    );

    stm_wr_decode u_wr_decode (
        .cclk      (cclk),
        .rst_n_i   (rst_n_i),
        .wen_i     (i_wen_i),
        .waddr_i   (i_waddr_i),
        .wdata_i   (i_wdata_i),
        .wr_en_o   (wr_en),
        .wr_row_o  (wr_row),
        .wr_data_o (wr_data)
    );

    stm_bank_merge u_bank_merge (
        .cclk       (cclk),
        .rst_n_i    (rst_n_i),
        .req        (rd_req_if.dst),
        .wr_en_i    (wr_en),
        .wr_row_i   (wr_row),
        .wr_data_i  (wr_data),
        .tag_offs_i (tag_offs),
        .tag_vld_i  (tag_vld),
        .rdata_o    (o_rdata_o),
        .rvalid_o   (o_rvalid_o),
        .roffs_o    (o_roffs_o),
        .rcoll_o    (o_rcoll_o)
    );

endmodule

// ==== hw/stm_wr_decode.sv ====
/*
 * Write request decode for the single write port.
 * Write data is per chunk and unrotated: word c lands in chunk c, on the
 * line that the chunk mapping gives for the write address.
 */
`timescale 1ns/1ps
`include "stm_config.svh"

module stm_wr_decode (
    input  logic                                    cclk,
    input  logic                                    rst_n_i,
    input  logic [`STM_CHUNKS-1:0]                  wen_i,      // Per chunk enable
    input  stm_pkg::addr_t                          waddr_i,    // Start address
    input  stm_pkg::word_t [`STM_CHUNKS-1:0]        wdata_i,    // Per chunk data
    output logic [`STM_BANKS-1:0][`STM_CHUNKS-1:0]  wr_en_o,    // One-hot bank per chunk
    output stm_pkg::row_t  [`STM_CHUNKS-1:0]        wr_row_o,
    output stm_pkg::word_t [`STM_CHUNKS-1:0]        wr_data_o
);

    stm_pkg::line_t wline [`STM_CHUNKS];                       // Line per chunk
    logic [`STM_BANKS-1:0][`STM_CHUNKS-1:0] wen_dec;           // Bank decoded enables

    // Same line mapping as the read ports
    always_comb begin
        for (int c = 0; c < `STM_CHUNKS; c++) begin
            wline[c] = stm_pkg::chunk_line(waddr_i, c);
        end
    end

    // Bank select per chunk
    always_comb begin
        for (int b = 0; b < `STM_BANKS; b++) begin
            for (int c = 0; c < `STM_CHUNKS; c++) begin
                wen_dec[b][c] = wen_i[c] && (wline[c].bank == stm_pkg::bank_t'(b));
            end
        end
    end

    always_ff @(posedge cclk) begin
        if (!rst_n_i) begin
            wr_en_o <= '0;
        end else begin
            wr_en_o <= wen_dec;                                // E1, RAM writes at E2
        end
    end

    // Row and data ride along with the enables
    always_ff @(posedge cclk) begin
        for (int c = 0; c < `STM_CHUNKS; c++) begin
            wr_row_o[c] <= wline[c].row;
        end
        wr_data_o <= wdata_i;
    end

endmodule

// ==== sim.f ====
+incdir+common
common/stm_pkg.sv
common/stm_rd_req_if.sv
hw/stm_bank_merge/stm_ram.sv
hw/stm_bank_merge/stm_bank_merge.sv
hw/stm_rd_decode.sv
hw/stm_wr_decode.sv
hw/stm_top.sv
verif/stm_tb.sv

// ==== verif/stm_tb.sv ====
/*
 * Testbench for the shared table memory.
 * Every output is checked three edges after its request against a flat
 * word model. Assumes the fixed read latency and no back-pressure.
 */
`timescale 1ns/1ps
`include "stm_config.svh"

module stm_tb;

    localparam int NP    = `STM_RPORTS;
    localparam int NC    = `STM_CHUNKS;
    localparam int AW    = `STM_ADDR_W;
    localparam int DW    = `STM_DATA_W;
    localparam int WORDS = `STM_BANKS * `STM_ROWS * `STM_CHUNKS;
    localparam int LAT   = 3;                       // Sample edge to output edge
    localparam int SLOTS = 4;                       // Expectation ring

    typedef logic [DW-1:0] word_t;

    logic                            cclk;
    logic                            rst_n_i;
    logic [NP-1:0][NC-1:0]           i_ren_i;
    logic [NP-1:0][AW-1:0]           i_raddr_i;
    logic [NC-1:0]                   i_wen_i;
    logic [AW-1:0]                   i_waddr_i;
    logic [NC-1:0][DW-1:0]           i_wdata_i;
    logic [NP-1:0]                   o_rvalid_o;
    logic [NP-1:0][`STM_CHUNK_AW-1:0] o_roffs_o;
    logic [NP-1:0][NC-1:0][DW-1:0]   o_rdata_o;
    logic [NP-1:0][NC-1:0]           o_rcoll_o;

    word_t                           model    [WORDS];  // Flat word image
    logic [NP-1:0]                   exp_vld  [SLOTS];
    logic [NP-1:0][`STM_CHUNK_AW-1:0] exp_offs [SLOTS];
    logic [NP-1:0][NC-1:0][DW-1:0]   exp_data [SLOTS];
    logic [NP-1:0][NC-1:0]           exp_coll [SLOTS];

    int     cyc;                                    // Edge count bumped 1 ns after the edge
    int     last_req;
    bit     check_en;
    int     errors;
    int     checks;
    int     test_no;
    int     bad_tests;
    integer seed;

    initial begin
        cclk = 1'b0;
        forever #10 cclk = ~cclk;
    end

    stm_top stm_top_i (
        .cclk       (cclk),
        .rst_n_i    (rst_n_i),
        .i_ren_i    (i_ren_i),
        .i_raddr_i  (i_raddr_i),
        .i_wen_i    (i_wen_i),
        .i_waddr_i  (i_waddr_i),
        .i_wdata_i  (i_wdata_i),
        .o_rvalid_o (o_rvalid_o),
        .o_roffs_o  (o_roffs_o),
        .o_rdata_o  (o_rdata_o),
        .o_rcoll_o  (o_rcoll_o)
    );

    // First word at or after addr that sits in chunk c
    function automatic int word_of(input int addr, input int c);
        return (addr + ((c - (addr % NC) + NC) % NC)) % WORDS;
    endfunction

    function automatic int bank_of(input int w);
        return w / (`STM_ROWS * NC);                // Bank is the top address field
    endfunction

    function automatic word_t fill_word(input int w);
        return word_t'((w * 515) ^ 32'h5a5a);       // Unique per word address
    endfunction

    task automatic report_value(input string sig, input logic [31:0] got,
                                input logic [31:0] expv);
        $display("FAILED at %0t: %s got %0h expected %0h", $time, sig, got, expv);
        errors++;
    endtask

    task automatic clear_slot(input int s);
        exp_vld[s]  = '0;
        exp_offs[s] = '0;
        exp_data[s] = '0;
        exp_coll[s] = '0;
    endtask

    // Output checks 1 ns after each edge
    initial begin : out_check
        int s;
        forever begin
            @(posedge cclk);
            #1;
            cyc++;
            s = cyc % SLOTS;
            if (check_en) begin
                for (int p = 0; p < NP; p++) begin
                    checks++;
                    assert (o_rvalid_o[p] === exp_vld[s][p]) else
                        report_value($sformatf("o_rvalid_o[%0d]", p),
                                     32'(o_rvalid_o[p]), 32'(exp_vld[s][p]));
                    if (exp_vld[s][p]) begin
                        assert (o_roffs_o[p] === exp_offs[s][p]) else
                            report_value($sformatf("o_roffs_o[%0d]", p),
                                         32'(o_roffs_o[p]), 32'(exp_offs[s][p]));
                    end
                    for (int c = 0; c < NC; c++) begin
                        assert (o_rdata_o[p][c] === exp_data[s][p][c]) else
                            report_value($sformatf("o_rdata_o[%0d][%0d]", p, c),
                                         32'(o_rdata_o[p][c]), 32'(exp_data[s][p][c]));
                        assert (o_rcoll_o[p][c] === exp_coll[s][p][c]) else
                            report_value($sformatf("o_rcoll_o[%0d][%0d]", p, c),
                                         32'(o_rcoll_o[p][c]), 32'(exp_coll[s][p][c]));
                    end
                end
            end
            clear_slot(s);
        end
    end

    // One cycle of stimulus plus its expected result
    task automatic drive(input logic [NP-1:0][NC-1:0] ren, input logic [NP-1:0][AW-1:0] raddr,
                         input logic [NC-1:0] wen, input logic [AW-1:0] waddr,
                         input logic [NC-1:0][DW-1:0] wdata);
        int s;
        int w;
        bit lost;
        @(posedge cclk);
        #2;
        i_ren_i   = ren;
        i_raddr_i = raddr;
        i_wen_i   = wen;
        i_waddr_i = waddr;
        i_wdata_i = wdata;
        s = (cyc + LAT) % SLOTS;                    // Checked LAT edges after sampling
        for (int p = 0; p < NP; p++) begin
            exp_vld[s][p]  = |ren[p];
            exp_offs[s][p] = raddr[p][`STM_CHUNK_AW-1:0];
            for (int c = 0; c < NC; c++) begin
                if (ren[p][c]) begin
                    w = word_of(raddr[p], c);
                    lost = 1'b0;
                    for (int q = p + 1; q < NP; q++) begin
                        if (ren[q][c] && bank_of(word_of(raddr[q], c)) == bank_of(w))
                            lost = 1'b1;            // Higher port takes the bank chunk
                    end
                    if (wen[c] && bank_of(word_of(waddr, c)) == bank_of(w))
                        lost = 1'b1;                // Write beats read
                    exp_coll[s][p][c] = lost;
                    exp_data[s][p][c] = lost ? '0 : model[w];
                end
            end
        end
        // Write lands after the reads sampled on the same edge
        for (int c = 0; c < NC; c++) begin
            if (wen[c]) model[word_of(waddr, c)] = wdata[c];
        end
        if (|ren || |wen) last_req = cyc;
    endtask

    task automatic drive_idle();
        drive('0, '0, '0, '0, '0);
    endtask

    task automatic read_one(input int port, input int addr);
        logic [NP-1:0][NC-1:0] ren;
        logic [NP-1:0][AW-1:0] raddr;
        ren         = '0;
        raddr       = '0;
        ren[port]   = '1;
        raddr[port] = AW'(addr);
        drive(ren, raddr, '0, '0, '0);
    endtask

    task automatic read_two(input int a0, input int a1);
        drive('1, {AW'(a1), AW'(a0)}, '0, '0, '0);  // Port 1 in the upper field
    endtask

    task automatic write_line(input int addr, input logic [NC-1:0][DW-1:0] data);
        drive('0, '0, '1, AW'(addr), data);
    endtask

    task automatic wait_valid(input int port, output int lat);
        lat = 0;
        while (o_rvalid_o[port] !== 1'b1 && lat < 10) begin
            drive_idle();
            lat++;
        end
        if (o_rvalid_o[port] !== 1'b1) begin
            $display("No read valid on port %0d within %0d cycles", port, lat);
            errors++;
        end
    endtask

    // Idle until the last request has been checked
    task automatic drain();
        int n;
        n = 0;
        while (cyc < last_req + LAT && n < 20) begin
            drive_idle();
            n++;
        end
        if (cyc < last_req + LAT) begin
            $display("Read results did not drain within %0d cycles", n);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_at_start);
        drain();
        test_no++;
        if (errors == err_at_start) begin
            $display("Test %0d %s: ok", test_no, name);
        end else begin
            bad_tests++;
            $display("Test %0d %s: %0d errors", test_no, name, errors - err_at_start);
        end
    endtask

    initial begin : main
        int                    e0;
        int                    lat;
        int                    port;
        int                    odd_addr [8];
        logic [31:0]           r;
        logic [NP-1:0][NC-1:0] ren;
        logic [NP-1:0][AW-1:0] raddr;
        logic [NC-1:0]         wen;
        logic [AW-1:0]         waddr;
        logic [NC-1:0][DW-1:0] wdata;
        seed      = 32'h42a0;
        odd_addr  = '{1, 31, 33, 63, 65, 95, 97, 127};  // Bank crossings and the top wrap
        rst_n_i   = 1'b0;
        i_ren_i   = '0;
        i_raddr_i = '0;
        i_wen_i   = '0;
        i_waddr_i = '0;
        i_wdata_i = '0;
        for (int s = 0; s < SLOTS; s++) clear_slot(s);
        repeat (16) @(posedge cclk);
        #2;
        rst_n_i  = 1'b1;
        check_en = 1'b1;

        e0 = errors;
        repeat (8) drive_idle();                    // Valid must stay low
        end_test("idle_after_reset", e0);

        e0 = errors;
        for (int a = 0; a < WORDS; a += NC) write_line(a, {fill_word(a + 1), fill_word(a)});
        for (int a = 0; a < WORDS; a += NC) begin
            port = (a / NC) % NP;
            read_one(port, a);
            wait_valid(port, lat);
            assert (lat == LAT) else begin
                $display("Read of %0d on port %0d came back after %0d cycles, not %0d",
                         a, port, lat, LAT);
                errors++;
            end
        end
        end_test("full_lines", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) read_one(i % NP, odd_addr[i]);
        end_test("split_lines", e0);

        e0 = errors;
        read_two(0, 64);                            // Different banks
        read_two(10, 12);                           // Same bank so port 0 loses both chunks
        read_two(30, 31);                           // Only chunk 1 shares bank 0
        read_two(127, 0);                           // Chunk 0 clash after the top wrap
        end_test("two_ports", e0);

        e0 = errors;
        drive({2'b00, 2'b11}, {AW'(0), AW'(20)}, '1, AW'(20), {16'hbeef, 16'h1234});
        read_one(0, 20);                            // Sees the new line
        drive({2'b11, 2'b00}, {AW'(22), AW'(0)}, '1, AW'(21), {16'hc0de, 16'h7777});
        read_one(1, 22);
        end_test("write_collision", e0);

        e0 = errors;
        for (int i = 0; i < 300; i++) begin
            r     = $random(seed);
            ren   = r[3:0];
            raddr = r[17:4];
            wen   = r[18] ? r[20:19] : 2'b00;
            waddr = r[27:21];
            wdata = $random(seed);
            drive(ren, raddr, wen, waddr, wdata);
        end
        end_test("random_traffic", e0);

        $display("Tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 test_no, bad_tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        for (int n = 0; n < 20000; n++) @(posedge cclk);
        $display("Simulation did not finish within 20000 cycles");
        $display("Testbench failed");
        $finish;
    end

endmodule
